// ==== include/uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Character width in bits.
`define UART_DATA_W 8

// Entries in each FIFO.
`define UART_FIFO_DEPTH 8

// Must cover UART_FIFO_DEPTH entries.
`define UART_PTR_W 3

`endif

// ==== source/uart_pkg.sv ====
`default_nettype none
`include "uart_macros.svh"

package uart_pkg;

	// Line settings shared by both directions.
	typedef struct packed {
		logic [15:0] div;       // Bit period minus one, in clock cycles.
		logic        parity_en; // Even parity bit after the data.
	} uart_cfg_t;

	// One received character with its error flags.
	typedef struct packed {
		logic [`UART_DATA_W-1:0] data;
		logic                    parity_err;
		logic                    frame_err;  // Stop bit sampled low.
	} uart_rx_t;

endpackage

`default_nettype wire

// ==== source/uart_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_fifo #(
	parameter type payload_t = logic [`UART_DATA_W-1:0],
	parameter int  depth     = `UART_FIFO_DEPTH
) (
	input  logic     clk,
	input  logic     rstn,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full
);
	localparam logic [`UART_PTR_W-1:0] last_ptr = `UART_PTR_W'(depth - 1);

	payload_t               mem [depth];
	logic [`UART_PTR_W-1:0] wr_ptr;
	logic [`UART_PTR_W-1:0] rd_ptr;
	logic [`UART_PTR_W:0]   count;
	logic                   do_push;
	logic                   do_pop;

	assign do_push = push & ~full;
	assign do_pop  = pop & ~empty;
	assign empty   = (count == '0);
	assign full    = (count == (`UART_PTR_W+1)'(depth));
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_tx (
	input  logic                    clk,
	input  logic                    rstn,
	input  uart_pkg::uart_cfg_t     cfg,
	input  logic [`UART_DATA_W-1:0] data,
	input  logic                    valid,
	output logic                    ready,
	output logic                    txd,
	output logic                    tx_busy
);
	localparam int cnt_w = $clog2(`UART_DATA_W);
	localparam int msb   = `UART_DATA_W - 1;

	typedef enum logic [2:0] {
		s_idle,
		s_start,
		s_data,
		s_parity,
		s_stop,
		s_check
	} state_t;

	state_t                  state;
	state_t                  state_next;
	logic [`UART_DATA_W-1:0] shreg;
	logic [cnt_w-1:0]        bit_cnt;
	logic                    parity;
	logic [15:0]             baud_cnt;
	logic                    baud_en;
	logic                    bit_done;
	logic                    load;

	assign baud_en  = (state != s_idle) && (state != s_check);
	assign bit_done = baud_en && (baud_cnt == cfg.div);
	assign load     = valid && ((state == s_idle) || (state == s_check));

	// Counts the cycles of the current bit.
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			baud_cnt <= '0;
		else if (!baud_en || bit_done)
			baud_cnt <= '0;
		else
			baud_cnt <= baud_cnt + 16'd1;
	end

	always_comb
	begin
		state_next = state;
		txd        = 1'b1;
		ready      = 1'b0;
		tx_busy    = 1'b1;
		case (state)
			s_idle:
			begin
				tx_busy = 1'b0;
				if (valid)
					state_next = s_start;
			end
			s_start:
			begin
				txd = 1'b0;
				if (bit_done)
					state_next = s_data;
			end
			s_data:
			begin
				txd = shreg[msb];
				if (bit_done && (bit_cnt == cnt_w'(msb)))
					state_next = cfg.parity_en ? s_parity : s_stop;
			end
			s_parity:
			begin
				txd = parity;
				if (bit_done)
					state_next = s_stop;
			end
			s_stop:
			begin
				if (bit_done)
				begin
					ready      = 1'b1; // Pops the FIFO head.
					state_next = s_check;
				end
			end
			s_check:
				state_next = valid ? s_start : s_idle; // Next byte if one waits.
			default:
				state_next = s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state   <= s_idle;
			bit_cnt <= '0;
			parity  <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (state == s_start)
			begin
				bit_cnt <= '0;
				parity  <= 1'b0;
			end
			else if ((state == s_data) && bit_done)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				parity  <= parity ^ shreg[msb]; // Even parity over sent bits.
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shreg <= data;
		else if ((state == s_data) && bit_done)
			shreg <= {shreg[msb-1:0], 1'b0}; // MSB goes out first.
	end

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_rx (
	input  logic                 clk,
	input  logic                 rstn,
	input  uart_pkg::uart_cfg_t  cfg,
	input  logic                 rxd,
	output logic                 push,
	output uart_pkg::uart_rx_t   result
);
	localparam int cnt_w = $clog2(`UART_DATA_W);
	localparam int msb   = `UART_DATA_W - 1;

	typedef enum logic [2:0] {
		s_idle,
		s_start,
		s_data,
		s_parity,
		s_stop
	} state_t;

	state_t                  state;
	logic                    rxd_meta;
	logic                    rxd_sync;
	logic                    rxd_last;
	logic [15:0]             cnt;
	logic [cnt_w-1:0]        bit_cnt;
	logic [`UART_DATA_W-1:0] shreg;
	logic                    par_err;
	logic                    sample;

	// Half a bit to the middle of the start bit, then whole bits.
	assign sample = (state == s_start) ? (cnt == {1'b0, cfg.div[15:1]}) : (cnt == cfg.div);

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state   <= s_idle;
			cnt     <= '0;
			bit_cnt <= '0;
			par_err <= 1'b0;
			push    <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			if ((state == s_idle) || sample)
				cnt <= '0;
			else
				cnt <= cnt + 16'd1;
			case (state)
				s_idle:
				begin
					if (rxd_last && !rxd_sync)
						state <= s_start; // Falling edge.
				end
				s_start:
				begin
					if (sample)
					begin
						bit_cnt <= '0;
						par_err <= 1'b0;
						state   <= rxd_sync ? s_idle : s_data; // Glitch if high.
					end
				end
				s_data:
				begin
					if (sample)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == cnt_w'(msb))
							state <= cfg.parity_en ? s_parity : s_stop;
					end
				end
				s_parity:
				begin
					if (sample)
					begin
						par_err <= rxd_sync ^ (^shreg);
						state   <= s_stop;
					end
				end
				s_stop:
				begin
					if (sample)
					begin
						push  <= 1'b1;
						state <= s_idle;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == s_data) && sample)
			shreg <= {shreg[msb-1:0], rxd_sync};
		if ((state == s_stop) && sample)
		begin
			result.data       <= shreg;
			result.parity_err <= par_err;
			result.frame_err  <= ~rxd_sync;
		end
	end

endmodule

`default_nettype wire

// ==== source/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_top (
	input  logic                    clk,
	input  logic                    rstn,
	input  uart_pkg::uart_cfg_t     cfg,
	input  logic                    wr_req,
	input  logic [`UART_DATA_W-1:0] wr_data,
	output logic                    wr_ack,
	input  logic                    rd_req,
	output uart_pkg::uart_rx_t      rd_data,
	output logic                    rd_ack,
	output logic                    txd,
	input  logic                    rxd,
	output logic                    tx_busy
);
	import uart_pkg::*;

	logic [`UART_DATA_W-1:0] tx_head;
	logic                    tx_empty;
	logic                    tx_full;
	logic                    tx_ready;
	logic                    wr_push;
	logic                    rx_push;
	logic                    rx_full;
	logic                    rx_empty;
	logic                    rd_pop;
	uart_rx_t                rx_result;

	assign wr_push = wr_req & ~wr_ack & ~tx_full; // Once per handshake.
	assign rd_pop  = rd_ack & ~rd_req;

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			wr_ack <= 1'b0;
			rd_ack <= 1'b0;
		end
		else
		begin
			if (wr_push)
				wr_ack <= 1'b1;
			else if (!wr_req)
				wr_ack <= 1'b0;
			if (rd_req && !rd_ack && !rx_empty)
				rd_ack <= 1'b1;
			else if (rd_pop)
				rd_ack <= 1'b0;
		end
	end

	uart_fifo #(.payload_t(logic [`UART_DATA_W-1:0])) u_tx_fifo (
		.clk(clk), .rstn(rstn), .push(wr_push), .push_data(wr_data),
		.pop(tx_ready), .head(tx_head), .empty(tx_empty), .full(tx_full)
	);

	uart_tx u_tx (
		.clk(clk), .rstn(rstn), .cfg(cfg), .data(tx_head), .valid(~tx_empty),
		.ready(tx_ready), .txd(txd), .tx_busy(tx_busy)
	);

	uart_rx u_rx (
		.clk(clk), .rstn(rstn), .cfg(cfg), .rxd(rxd), .push(rx_push), .result(rx_result)
	);

	// A character arriving on a full FIFO is dropped.
	uart_fifo #(.payload_t(uart_rx_t)) u_rx_fifo (
		.clk(clk), .rstn(rstn), .push(rx_push & ~rx_full), .push_data(rx_result),
		.pop(rd_pop), .head(rd_data), .empty(rx_empty), .full(rx_full)
	);

endmodule

`default_nettype wire

// ==== testbench/uart_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module uart_checker (
	input  logic                    clk,
	input  logic                    rstn,
	input  uart_pkg::uart_cfg_t     cfg,
	input  logic [`UART_DATA_W-1:0] wr_data,
	input  logic                    wr_ack,
	input  uart_pkg::uart_rx_t      rd_data,
	input  logic                    rd_ack,
	input  logic                    txd,
	input  logic                    rxd,
	input  logic                    tx_busy,
	input  logic                    drain,
	output int                      errors,
	output int                      checks,
	output int                      line_errors,
	output int                      frames
);
	import uart_pkg::*;

	logic [`UART_DATA_W-1:0] wr_q [$];  // Accepted bytes not yet seen on txd.
	uart_rx_t                rd_q [$];  // Results expected on rd_data.
	int                      err_cnt = 0;
	int                      chk_cnt = 0;
	int                      line_cnt = 0;
	int                      frame_cnt = 0;
	int                      accepted = 0;
	int                      started = 0;
	int                      since_rst = 0;
	logic                    wr_ack_q = 1'b0;
	logic                    rd_ack_q = 1'b0;
	// Index 0 follows txd, index 1 follows rxd.
	logic                    active [2] = '{1'b0, 1'b0};
	logic                    prev [2] = '{1'b1, 1'b1};
	logic                    held [2];
	int                      idx [2];
	logic [`UART_DATA_W+2:0] bits [2];

	assign errors      = err_cnt;
	assign checks      = chk_cnt;
	assign line_errors = line_cnt;
	assign frames      = frame_cnt;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp, input logic on_line);
		chk_cnt++;
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			err_cnt++;
			if (on_line)
				line_cnt++;
		end
	endtask

	task automatic report_fault(input string what, input logic on_line);
		$display("%s", what);
		err_cnt++;
		if (on_line)
			line_cnt++;
	endtask

	task automatic frame_done(input int l, input int nbits);
		logic [`UART_DATA_W-1:0] d;
		logic [`UART_DATA_W-1:0] exp_b;
		logic                    par;
		logic                    stop;
		uart_rx_t                r;
		d = '0;
		for (int k = 1; k <= `UART_DATA_W; k++)
			d = {d[`UART_DATA_W-2:0], bits[l][k]};
		par  = bits[l][`UART_DATA_W+1];
		stop = bits[l][nbits-1];
		if (l == 0)
		begin
			frame_cnt++;
			if (wr_q.size() == 0)
				report_fault("A frame appeared on txd without any accepted write", 1'b1);
			else
			begin
				exp_b = wr_q.pop_front();
				check_value("txd start", 32'(bits[0][0]), 32'h0, 1'b1);
				check_value("txd data", 32'(d), 32'(exp_b), 1'b1);
				if (cfg.parity_en)
					check_value("txd parity", 32'(par), 32'(^exp_b), 1'b1); // Even parity.
				check_value("txd stop", 32'(stop), 32'h1, 1'b1);
			end
		end
		else if (!bits[1][0])
		begin
			r.data       = d;
			r.parity_err = cfg.parity_en && (par != ^d);
			r.frame_err  = !stop;
			rd_q.push_back(r);
		end
	endtask

	// Samples one line per clock and rebuilds frames at the bit middles.
	task automatic step_line(input int l, input logic v);
		int per;
		int nbits;
		int k;
		int c;
		per   = int'(cfg.div) + 1;
		nbits = cfg.parity_en ? `UART_DATA_W + 3 : `UART_DATA_W + 2;
		if (!active[l] && prev[l] && !v)
		begin
			active[l] = 1'b1;
			idx[l]    = 0;
			if (l == 0)
				started++; // Byte has left the FIFO model.
		end
		if (active[l])
		begin
			k = idx[l] / per;
			c = idx[l] % per;
			if (c == 0)
				held[l] = v;
			else if (v !== held[l])
				report_fault($sformatf("%s changed inside bit %0d of a frame",
					(l == 0) ? "txd" : "rxd", k), 1'b1);
			if (c == per / 2)
			begin
				bits[l][k] = v;
				if (k == nbits - 1)
					frame_done(l, nbits);
			end
			idx[l]++;
			if (idx[l] == nbits * per)
				active[l] = 1'b0;
		end
		prev[l] = v;
	endtask

	always @(negedge clk)
	begin
		if (!rstn || since_rst < 3)
		begin
			check_value("txd", 32'(txd), 32'h1, 1'b0);
			check_value("wr_ack", 32'(wr_ack), 32'h0, 1'b0);
			check_value("rd_ack", 32'(rd_ack), 32'h0, 1'b0);
			check_value("tx_busy", 32'(tx_busy), 32'h0, 1'b0);
		end
		if (rstn)
		begin
			if (since_rst < 3)
				since_rst++;
			step_line(0, txd);
			step_line(1, rxd);
			if (wr_ack && !wr_ack_q)
			begin
				chk_cnt++;
				if (accepted - started >= `UART_FIFO_DEPTH)
					report_fault("wr_ack rose while the transmit FIFO model was full", 1'b0);
				accepted++;
				wr_q.push_back(wr_data);
			end
			if (rd_ack && !rd_ack_q)
			begin
				if (rd_q.size() == 0)
					report_fault("rd_ack rose with no frame received on rxd", 1'b0);
				else
					check_value("rd_data", 32'(rd_data), 32'(rd_q.pop_front()), 1'b0);
			end
			if (drain && (wr_q.size() != 0 || rd_q.size() != 0))
				report_fault($sformatf("%0d written and %0d received characters never came out",
					wr_q.size(), rd_q.size()), 1'b0);
		end
		wr_ack_q = wr_ack;
		rd_ack_q = rd_ack;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_uart.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "uart_macros.svh"

module tb_uart;
	import uart_pkg::*;

	localparam int n_frames    = 40 + 40 + 2 + `UART_FIFO_DEPTH + 4;
	localparam int max_div     = 12;
	localparam int watchdog_ns = n_frames * 11 * (max_div + 1) * 20 + 100000;

	logic                    clk;
	logic                    rstn;
	uart_cfg_t               cfg;
	logic                    wr_req;
	logic [`UART_DATA_W-1:0] wr_data;
	logic                    wr_ack;
	logic                    rd_req;
	uart_rx_t                rd_data;
	logic                    rd_ack;
	logic                    txd;
	logic                    rxd;
	logic                    tx_busy;
	logic                    rxd_sel;   // High hands rxd to the frame injector.
	logic                    rxd_drv;
	logic                    drain;
	int                      errors;
	int                      checks;
	int                      line_errors;
	int                      frames;
	int                      seed;
	int                      n_tests;
	int                      n_failed;
	int                      errs_seen;

	assign rxd = rxd_sel ? rxd_drv : txd;

	uart_top i_uart_top (
		.clk(clk), .rstn(rstn), .cfg(cfg), .wr_req(wr_req), .wr_data(wr_data),
		.wr_ack(wr_ack), .rd_req(rd_req), .rd_data(rd_data), .rd_ack(rd_ack),
		.txd(txd), .rxd(rxd), .tx_busy(tx_busy)
	);

	uart_checker i_uart_checker (
		.clk(clk), .rstn(rstn), .cfg(cfg), .wr_data(wr_data), .wr_ack(wr_ack),
		.rd_data(rd_data), .rd_ack(rd_ack), .txd(txd), .rxd(rxd), .tx_busy(tx_busy),
		.drain(drain), .errors(errors), .checks(checks), .line_errors(line_errors),
		.frames(frames)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	task automatic write_byte(input logic [`UART_DATA_W-1:0] b);
		@(posedge clk);
		wr_req  <= 1'b1;
		wr_data <= b;
		do
			@(negedge clk);
		while (!wr_ack);
		@(posedge clk);
		wr_req <= 1'b0;
		do
			@(negedge clk);
		while (wr_ack);
	endtask

	task automatic read_result;
		@(posedge clk);
		rd_req <= 1'b1;
		do
			@(negedge clk);
		while (!rd_ack);
		repeat ({$random(seed)} % 4)
			@(posedge clk);
		@(posedge clk);
		rd_req <= 1'b0;
		do
			@(negedge clk);
		while (rd_ack);
	endtask

	task automatic run_traffic(input int n, input logic [15:0] div, input logic par,
		input logic burst);
		@(posedge clk);
		cfg.div       <= div;
		cfg.parity_en <= par;
		fork
			begin
				for (int i = 0; i < n; i++)
				begin
					if (!burst)
						repeat ({$random(seed)} % 16)
							@(posedge clk);
					write_byte(`UART_DATA_W'($random(seed)));
				end
			end
			begin
				for (int i = 0; i < n; i++)
					read_result();
			end
		join
		do
			@(negedge clk);
		while (tx_busy);
	endtask

	// Drives one frame on rxd, then two idle bits.
	task automatic send_frame(input logic [`UART_DATA_W-1:0] b, input logic bad_par,
		input logic bad_stop);
		logic [`UART_DATA_W+2:0] bits;
		int                      nbits;
		nbits   = cfg.parity_en ? `UART_DATA_W + 3 : `UART_DATA_W + 2;
		bits    = '1;
		bits[0] = 1'b0;
		for (int k = 0; k < `UART_DATA_W; k++)
			bits[k + 1] = b[`UART_DATA_W - 1 - k];
		if (cfg.parity_en)
			bits[`UART_DATA_W + 1] = (^b) ^ bad_par;
		bits[nbits - 1] = ~bad_stop;
		for (int k = 0; k < nbits + 2; k++)
			repeat (int'(cfg.div) + 1)
			begin
				@(posedge clk);
				rxd_drv <= (k < nbits) ? bits[k] : 1'b1;
			end
	endtask

	task automatic run_injection;
		logic [`UART_DATA_W-1:0] b0;
		logic [`UART_DATA_W-1:0] b1;
		b0 = `UART_DATA_W'($random(seed));
		b1 = `UART_DATA_W'($random(seed));
		@(posedge clk);
		cfg.div       <= 16'd12;
		cfg.parity_en <= 1'b1;
		rxd_drv       <= 1'b1;
		rxd_sel       <= 1'b1;
		@(posedge clk);
		fork
			begin
				send_frame(b0, 1'b1, 1'b0);
				send_frame(b1, 1'b0, 1'b1);
			end
			begin
				read_result();
				read_result();
			end
		join
		@(posedge clk);
		rxd_sel <= 1'b0;
	endtask

	task automatic end_test(input string name);
		@(posedge clk);
		drain <= 1'b1;
		@(posedge clk);
		drain <= 1'b0;
		@(posedge clk);
		n_tests++;
		if (errors != errs_seen)
		begin
			n_failed++;
			$display("%-16s FAIL, %0d errors", name, errors - errs_seen);
		end
		else
			$display("%-16s pass", name);
		errs_seen = errors;
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("Run timed out after %0d ns with a handshake or frame still open", watchdog_ns);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		seed          = 9518;
		n_tests       = 0;
		n_failed      = 0;
		errs_seen     = 0;
		rstn          = 1'b0;
		cfg.div       = 16'd7;
		cfg.parity_en = 1'b0;
		wr_req        = 1'b0;
		wr_data       = '0;
		rd_req        = 1'b0;
		rxd_sel       = 1'b0;
		rxd_drv       = 1'b1;
		drain         = 1'b0;
		repeat (5)
			@(posedge clk);
		rstn <= 1'b1;
		repeat (3)
			@(posedge clk);
		end_test("reset state");
		run_traffic(40, 16'd7, 1'b0, 1'b0);
		end_test("loopback order");
		run_traffic(40, 16'd12, 1'b1, 1'b0);
		end_test("parity");
		run_injection();
		end_test("error detection");
		run_traffic(`UART_FIFO_DEPTH + 4, 16'd7, 1'b0, 1'b1); // Fills the transmit FIFO.
		end_test("back-pressure");
		n_tests++;
		if (line_errors == 0)
			$display("%-16s pass, %0d frames", "line format", frames);
		else
		begin
			n_failed++;
			$display("%-16s FAIL, %0d errors in %0d frames", "line format", line_errors, frames);
		end
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			n_tests, n_failed, checks, errors);
		if (n_failed == 0 && errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
testbench/uart_checker.sv
testbench/tb_uart.sv

// ==== Makefile ====
# Builds the UART testbench with Verilator and runs it.
TOP := tb_uart
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, then search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary -sv -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "All tests passed!" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
